// File: rtl/cpc_pkg.sv
`default_nettype none

package cpc_pkg;

    // ------------------------------------------------------------
    // Bus structs
    // ------------------------------------------------------------
    typedef struct packed {
        logic        download;  // High for the whole transfer
        logic        wr;        // One strobe per byte
        logic [7:0]  index;     // Menu slot of the file
        logic [24:0] addr;      // Byte offset in the file
        logic [7:0]  data;
    } ioctl_t;

    typedef struct packed {
        logic        valid;
        logic [22:0] addr;      // Bank in 22..14, offset in 13..0
        logic [7:0]  data;
    } boot_wr_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  dout;      // Z80 data out
        logic        io_wr;
        logic        mem_wr;
        logic        mem_rd;
        logic        m1;        // Opcode fetch
    } cpu_bus_t;

    typedef struct packed {
        logic        we;
        logic [12:0] addr;
        logic [7:0]  data;
    } mf2_req_t;

    // ------------------------------------------------------------
    // ROM banks and MF2 layout
    // ------------------------------------------------------------
    localparam logic [8:0]  BANK_OS           = 9'h000;  // OS6128
    localparam logic [8:0]  BANK_BASIC        = 9'h100;  // BASIC 1.1
    localparam logic [8:0]  BANK_AMSDOS       = 9'h107;
    localparam logic [8:0]  BANK_MF2          = 9'h0ff;
    localparam int          ROM_SLOTS         = 4;

    // Shadow cells in the top of MF2 RAM
    localparam logic [12:0] MF2_CELL_PEN      = 13'h1fcf;
    localparam logic [12:0] MF2_CELL_BORDER   = 13'h1fdf;
    localparam logic [12:0] MF2_CELL_MODE     = 13'h1fef;
    localparam logic [12:0] MF2_CELL_BANK     = 13'h1fff;
    localparam logic [12:0] MF2_CELL_CRTC_SEL = 13'h1cff;
    localparam logic [12:0] MF2_CELL_8255     = 13'h17ff;
    localparam logic [12:0] MF2_CELL_UROM     = 13'h1aac;
    localparam logic [8:0]  MF2_PEN_BASE      = 9'h1f9;  // Plus pen number
    localparam logic [8:0]  MF2_CRTC_BASE     = 9'h1db;  // Plus CRTC register

    localparam logic [15:0] MF2_NMI_VECTOR    = 16'h0066;
    localparam logic [15:0] MF2_HIDE_ADDR     = 16'h0065;
    localparam logic [13:0] MF2_PAGE_PORT     = 14'h3fba;  // FEE8 and FEEA

endpackage

`default_nettype wire

// File: rtl/rom_loader.sv
`timescale 1ns/10ps
`default_nettype none

module rom_loader
    import cpc_pkg::*;
#(
    parameter int ROM_MAP_BITS = 256
) (
    input  logic                    clk_48,
    input  logic                    reset,
    input  ioctl_t                  ioctl,
    output boot_wr_t                boot_wr,
    output logic [ROM_MAP_BITS-1:0] rom_map,
    output logic                    rom_loaded,
    output logic                    core_reset
);

    logic       old_download;
    logic       byte_take;     // Download byte this cycle
    logic       rom_accept;    // Byte lands in a ROM bank
    logic [8:0] slot_bank;

    assign byte_take  = ioctl.download & ioctl.wr;
    assign rom_accept = byte_take
                      & (ioctl.index[4:0] < ROM_SLOTS)
                      & (ioctl.addr[24:14] < ROM_SLOTS);

    // Each 16 KB file slot goes to a fixed bank
    always_comb begin
        case (ioctl.addr[15:14])
            2'd0:    slot_bank = BANK_OS;
            2'd1:    slot_bank = BANK_BASIC;
            2'd2:    slot_bank = BANK_AMSDOS;
            default: slot_bank = BANK_MF2;
        endcase
    end

    // ------------------------------------------------------------
    // Boot write register
    // ------------------------------------------------------------
    always_ff @(posedge clk_48) begin
        boot_wr.addr <= {slot_bank, ioctl.addr[13:0]};
        boot_wr.data <= ioctl.data;
        if (reset) begin
            boot_wr.valid <= 1'b0;
        end else begin
            boot_wr.valid <= rom_accept;  // Single cycle strobe
        end
    end

    // ------------------------------------------------------------
    // ROM present map, one bit per upper bank
    // ------------------------------------------------------------
    always_ff @(posedge clk_48) begin
        if (reset) begin
            rom_map <= '0;
        end else if (boot_wr.valid) begin
            if (boot_wr.addr[22])
                rom_map[boot_wr.addr[21:14]] <= 1'b1;  // Expansion ROM
            else if (boot_wr.addr[22:14] == BANK_OS)
                rom_map[0] <= 1'b1;                    // Lower ROM
        end
    end

    // Core held in reset until first download finishes
    always_ff @(posedge clk_48) begin
        old_download <= ioctl.download;
        if (reset) begin
            rom_loaded <= 1'b0;
            core_reset <= 1'b1;
        end else if (old_download & ~ioctl.download) begin
            rom_loaded <= 1'b1;
            core_reset <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/mf2_snoop.sv
`timescale 1ns/10ps
`default_nettype none

module mf2_snoop
    import cpc_pkg::*;
(
    input  logic     clk_48,
    input  logic     reset,
    input  cpu_bus_t cpu,
    input  logic     ram_sel,   // CPU address inside paged MF2 RAM
    output mf2_req_t ram_req
);

    logic        old_io_wr;
    logic        io_wr_rise;
    logic        shadow_hit;    // Port is one we copy
    logic [12:0] store_addr;
    logic [4:0]  pen_index;     // Last gate array pen select
    logic [3:0]  crtc_index;    // Last CRTC register select

    assign io_wr_rise = cpu.io_wr & ~old_io_wr;

    // ------------------------------------------------------------
    // Shadow cell decode
    // ------------------------------------------------------------
    always_comb begin
        shadow_hit = 1'b1;
        store_addr = '0;
        case (cpu.addr[15:8])
            8'h7f: begin  // Gate array, function in data bits 7..6
                case (cpu.dout[7:6])
                    2'b00:   store_addr = MF2_CELL_PEN;
                    2'b01:   store_addr = pen_index[4] ? MF2_CELL_BORDER
                                                       : {MF2_PEN_BASE, pen_index[3:0]};
                    2'b10:   store_addr = MF2_CELL_MODE;
                    default: store_addr = MF2_CELL_BANK;
                endcase
            end
            8'hbc:   store_addr = MF2_CELL_CRTC_SEL;
            8'hbd:   store_addr = {MF2_CRTC_BASE, crtc_index};  // CRTC data
            8'hf7:   store_addr = MF2_CELL_8255;                // PPI control
            8'hdf:   store_addr = MF2_CELL_UROM;                // Upper ROM select
            default: shadow_hit = 1'b0;
        endcase
    end

    // Index registers track selects for later data writes
    always_ff @(posedge clk_48) begin
        if (reset) begin
            pen_index  <= '0;
            crtc_index <= '0;
        end else if (io_wr_rise) begin
            if (cpu.addr[15:8] == 8'h7f && cpu.dout[7:6] == 2'b00)
                pen_index <= cpu.dout[4:0];
            if (cpu.addr[15:8] == 8'hbc)
                crtc_index <= cpu.dout[3:0];
        end
    end

    // ------------------------------------------------------------
    // RAM port command
    // ------------------------------------------------------------
    always_ff @(posedge clk_48) begin
        old_io_wr    <= cpu.io_wr;
        ram_req.addr <= cpu.addr[12:0];  // Read or normal write
        ram_req.data <= cpu.dout;
        ram_req.we   <= 1'b0;
        if (reset) begin
            ram_req.we <= 1'b0;
        end else if (io_wr_rise && shadow_hit) begin
            ram_req.addr <= store_addr;    // Copy of hardware register
            ram_req.we   <= 1'b1;
        end else if (cpu.mem_wr && ram_sel) begin
            ram_req.we   <= 1'b1;          // CPU store into MF2 RAM
        end
    end

endmodule

`default_nettype wire

// File: rtl/mf2_ram.sv
`timescale 1ns/10ps
`default_nettype none

module mf2_ram
    import cpc_pkg::*;
#(
    parameter int MF2_ADDR_BITS = 13
) (
    input  logic       clk_48,
    input  mf2_req_t   req,
    output logic [7:0] q
);

    logic [7:0]               mem [2**MF2_ADDR_BITS];
    logic [MF2_ADDR_BITS-1:0] word_addr;

    assign word_addr = req.addr[MF2_ADDR_BITS-1:0];

    // Single port, write data shows on q in the write cycle
    always_ff @(posedge clk_48) begin
        if (req.we) begin
            mem[word_addr] <= req.data;
            q              <= req.data;
        end else begin
            q <= mem[word_addr];
        end
    end

endmodule

`default_nettype wire

// File: rtl/mf2_pager.sv
`timescale 1ns/10ps
`default_nettype none

module mf2_pager
    import cpc_pkg::*;
(
    input  logic       clk_48,
    input  logic       reset,
    input  cpu_bus_t   cpu,
    input  logic       key_nmi,    // Stop button level
    input  logic [7:0] ram_q,
    output logic       ram_sel,
    output logic [7:0] mf2_dout,
    output logic       mf2_en,
    output logic       mf2_nmi
);

    logic old_key_nmi;
    logic old_m1;
    logic old_io_wr;
    logic key_rise;
    logic m1_rise;
    logic io_wr_rise;
    logic mf2_hidden;   // Set by fetch at 0065, blocks paging port

    assign key_rise   = key_nmi & ~old_key_nmi;
    assign m1_rise    = cpu.m1 & ~old_m1;
    assign io_wr_rise = cpu.io_wr & ~old_io_wr;

    // RAM sits at 2000..3FFF while paged in
    assign ram_sel  = mf2_en & (cpu.addr[15:13] == 3'b001);
    assign mf2_dout = (ram_sel & cpu.mem_rd) ? ram_q : 8'hff;  // FF for AND merge

    // ------------------------------------------------------------
    // Paging state
    // ------------------------------------------------------------
    always_ff @(posedge clk_48) begin
        old_key_nmi <= key_nmi;
        old_m1      <= cpu.m1;
        old_io_wr   <= cpu.io_wr;
        if (reset) begin
            mf2_nmi    <= 1'b0;
            mf2_en     <= 1'b0;
            mf2_hidden <= 1'b0;
        end else begin
            if (key_rise && !mf2_en)
                mf2_nmi <= 1'b1;
            // NMI acknowledged by the fetch at the vector
            if (mf2_nmi && m1_rise && cpu.addr == MF2_NMI_VECTOR) begin
                mf2_en     <= 1'b1;
                mf2_hidden <= 1'b0;
                mf2_nmi    <= 1'b0;
            end
            if (mf2_en && m1_rise && cpu.addr == MF2_HIDE_ADDR)
                mf2_hidden <= 1'b1;
            if (io_wr_rise && cpu.addr[15:2] == MF2_PAGE_PORT)
                mf2_en <= ~cpu.addr[1] & ~mf2_hidden;  // FEE8 in, FEEA out
        end
    end

endmodule

`default_nettype wire

// File: rtl/cpc_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module cpc_mem_top
    import cpc_pkg::*;
#(
    parameter int ROM_MAP_BITS  = 256,
    parameter int MF2_ADDR_BITS = 13
) (
    input  logic                    clk_48,
    input  logic                    reset,
    input  ioctl_t                  ioctl,
    input  cpu_bus_t                cpu,
    input  logic                    key_nmi,
    output boot_wr_t                boot_wr,
    output logic [ROM_MAP_BITS-1:0] rom_map,
    output logic                    rom_loaded,
    output logic [7:0]              mf2_dout,
    output logic                    mf2_en,
    output logic                    mf2_nmi
);

    logic       core_reset;  // Low once the first download is done
    logic       ram_sel;
    mf2_req_t   ram_req;
    logic [7:0] ram_q;

    // ------------------------------------------------------------
    // Download side
    // ------------------------------------------------------------
    rom_loader #(
        .ROM_MAP_BITS (ROM_MAP_BITS)
    ) u_rom_loader (
        .clk_48     (clk_48),
        .reset      (reset),
        .ioctl      (ioctl),
        .boot_wr    (boot_wr),
        .rom_map    (rom_map),
        .rom_loaded (rom_loaded),
        .core_reset (core_reset)
    );

    // ------------------------------------------------------------
    // Multiface Two
    // ------------------------------------------------------------
    mf2_snoop u_mf2_snoop (
        .clk_48  (clk_48),
        .reset   (core_reset),
        .cpu     (cpu),
        .ram_sel (ram_sel),
        .ram_req (ram_req)
    );

    mf2_ram #(
        .MF2_ADDR_BITS (MF2_ADDR_BITS)
    ) u_mf2_ram (
        .clk_48 (clk_48),
        .req    (ram_req),
        .q      (ram_q)
    );

    mf2_pager u_mf2_pager (
        .clk_48   (clk_48),
        .reset    (core_reset),
        .cpu      (cpu),
        .key_nmi  (key_nmi),
        .ram_q    (ram_q),
        .ram_sel  (ram_sel),
        .mf2_dout (mf2_dout),
        .mf2_en   (mf2_en),
        .mf2_nmi  (mf2_nmi)
    );

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;  // 50 % duty
    end

endmodule

`default_nettype wire

// File: sim/cpc_mem_assert.sv
`timescale 1ns/10ps
`default_nettype none

module cpc_mem_assert
    import cpc_pkg::*;
(
    input logic       clk_48,
    input logic       reset,
    input cpu_bus_t   cpu,
    input boot_wr_t   boot_wr,
    input logic [7:0] mf2_dout,
    input logic       mf2_en,
    input logic       mf2_nmi
);

    // ------------------------------------------------------------
    // Loader quiet while reset is applied
    // ------------------------------------------------------------
    boot_quiet_in_reset: assert property (
        @(posedge clk_48) $past(reset) |-> !boot_wr.valid
    ) else $error("boot write valid after a reset cycle");

    // Read data idles at FF for the AND merge on the CPU bus
    dout_idle_ff: assert property (
        @(posedge clk_48) disable iff (reset)
        !cpu.mem_rd |-> mf2_dout == 8'hff
    ) else $error("mf2_dout not FF without a memory read");

    // ------------------------------------------------------------
    // NMI acknowledge, fetch at 0066 pages in and drops the NMI
    // ------------------------------------------------------------
    nmi_clear_on_enter: assert property (
        @(posedge clk_48) disable iff (reset)
        $rose(mf2_en) && $past(cpu.m1 && cpu.addr == MF2_NMI_VECTOR) |-> !mf2_nmi
    ) else $error("mf2_nmi still high after paging in at 0066");

endmodule

`default_nettype wire

// File: sim/tb_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_top
    import cpc_pkg::*;
();

    localparam int READ_DELAY   = 3;   // Snoop register, RAM register, then sample
    localparam int FLAG_TIMEOUT = 32;  // Cycles allowed for flags to settle

    logic         clk_48;
    logic         reset;
    ioctl_t       ioctl;
    cpu_bus_t     cpu;
    logic         key_nmi;
    boot_wr_t     boot_wr;
    logic [255:0] rom_map;
    logic         rom_loaded;
    logic [7:0]   mf2_dout;
    logic         mf2_en;
    logic         mf2_nmi;

    tb_clock #(.PERIOD_NS (4)) u_clock (.clk (clk_48));

    cpc_mem_top #(
        .ROM_MAP_BITS  (256),
        .MF2_ADDR_BITS (13)
    ) u_dut (
        .clk_48     (clk_48),
        .reset      (reset),
        .ioctl      (ioctl),
        .cpu        (cpu),
        .key_nmi    (key_nmi),
        .boot_wr    (boot_wr),
        .rom_map    (rom_map),
        .rom_loaded (rom_loaded),
        .mf2_dout   (mf2_dout),
        .mf2_en     (mf2_en),
        .mf2_nmi    (mf2_nmi)
    );

    bind cpc_mem_top cpc_mem_assert u_assert (
        .clk_48   (clk_48),
        .reset    (reset),
        .cpu      (cpu),
        .boot_wr  (boot_wr),
        .mf2_dout (mf2_dout),
        .mf2_en   (mf2_en),
        .mf2_nmi  (mf2_nmi)
    );

    // ------------------------------------------------------------
    // Error stop and compare tasks
    // ------------------------------------------------------------
    task automatic stop_run(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "testbench stopped at first error");
    endtask

    task automatic check_boot(input string name, input boot_wr_t exp, input boot_wr_t act);
        // Addr and data only matter with valid set
        if (exp.valid ? (act !== exp) : (act.valid !== 1'b0))
            stop_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
            stop_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic check_flags(input string name, input logic [2:0] exp, input logic [2:0] act);
        if (act !== exp)  // {mf2_en, mf2_nmi, rom_loaded}
            stop_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
    endtask

    // ------------------------------------------------------------
    // Bus actions, all driven on the falling edge
    // ------------------------------------------------------------
    task automatic download_byte(input string name, input logic [7:0] idx,
                                 input logic [24:0] addr, input logic [7:0] data,
                                 input boot_wr_t exp);
        ioctl.wr    = 1'b1;
        ioctl.index = idx;
        ioctl.addr  = addr;
        ioctl.data  = data;
        @(negedge clk_48);
        ioctl.wr = 1'b0;
        check_boot(name, exp, boot_wr);  // Registered one edge after take
    endtask

    task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
        cpu.addr  = addr;
        cpu.dout  = data;
        cpu.io_wr = 1'b1;
        @(negedge clk_48);
        cpu.io_wr = 1'b0;
        @(negedge clk_48);  // Low cycle so the next write is a new edge
    endtask

    task automatic m1_fetch(input logic [15:0] addr);
        cpu.addr = addr;
        cpu.m1   = 1'b1;
        @(negedge clk_48);
        cpu.m1 = 1'b0;
        @(negedge clk_48);
    endtask

    task automatic mem_store(input logic [15:0] addr, input logic [7:0] data);
        cpu.addr   = addr;
        cpu.dout   = data;
        cpu.mem_wr = 1'b1;
        @(negedge clk_48);
        cpu.mem_wr = 1'b0;
    endtask

    task automatic mem_read(input string name, input logic [15:0] addr, input logic [7:0] exp);
        int i;
        cpu.addr   = addr;
        cpu.mem_rd = 1'b1;
        for (i = 0; i < READ_DELAY; i++)
            @(negedge clk_48);
        check_byte(name, exp, mf2_dout);
        cpu.mem_rd = 1'b0;
    endtask

    task automatic wait_flags(input string name, input logic [2:0] exp);
        int cycles;
        cycles = 0;
        while ({mf2_en, mf2_nmi, rom_loaded} !== exp && cycles < FLAG_TIMEOUT) begin
            @(negedge clk_48);
            cycles++;
        end
        if ({mf2_en, mf2_nmi, rom_loaded} !== exp)
            $display("Timeout after %0d cycles waiting for flags in %s", cycles, name);
        check_flags(name, exp, {mf2_en, mf2_nmi, rom_loaded});
    endtask

    task automatic idle(input int n);
        int i;
        for (i = 0; i < n; i++)
            @(negedge clk_48);
    endtask

    // ------------------------------------------------------------
    // Command interpreter over the data file
    // ------------------------------------------------------------
    initial begin
        int          fd;
        int          line_no;
        string       line;
        string       name;
        byte         cmd;
        logic [31:0] f0, f1, f2, f3, f4;
        boot_wr_t    exp_boot;

        reset     = 1'b1;
        ioctl     = '0;
        cpu       = '0;
        key_nmi   = 1'b0;
        line_no   = 0;
        fd = $fopen("sim/testdata_mem.txt", "r");
        if (fd == 0)
            stop_run("Could not open the data file sim/testdata_mem.txt");
        idle(2);
        ioctl.download = 1'b1;    // Slot 0 strobes inside reset stay off boot_wr
        ioctl.wr       = 1'b1;
        idle(4);
        ioctl = '0;               // Level low again well before release
        idle(4);                  // Reset held 10 cycles
        reset = 1'b0;

        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            f0 = '0;
            f1 = '0;
            f2 = '0;
            f3 = '0;
            f4 = '0;
            void'($sscanf(line, "%c %h %h %h %h %h", cmd, f0, f1, f2, f3, f4));
            name = $sformatf("line %0d cmd %c", line_no, cmd);
            case (cmd)
                "L": begin
                    ioctl.download = f0[0];
                    @(negedge clk_48);
                end
                "D": begin
                    exp_boot.valid = f3[0];
                    exp_boot.addr  = f4[22:0];
                    exp_boot.data  = f2[7:0];
                    download_byte(name, f0[7:0], f1[24:0], f2[7:0], exp_boot);
                end
                "M": check_bit(name, f1[0], rom_map[f0[7:0]]);
                "K": begin
                    key_nmi = 1'b1;  // Stop button press
                    @(negedge clk_48);
                    key_nmi = 1'b0;
                    @(negedge clk_48);
                end
                "F": m1_fetch(f0[15:0]);
                "O": io_write(f0[15:0], f1[7:0]);
                "S": mem_store(f0[15:0], f1[7:0]);
                "R": mem_read(name, f0[15:0], f1[7:0]);
                "C": wait_flags(name, {f0[0], f1[0], f2[0]});
                "I": idle(f0);
                default: stop_run($sformatf("Unknown command in line %0d", line_no));
            endcase
        end
        $fclose(fd);

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
rtl/cpc_pkg.sv
rtl/rom_loader.sv
rtl/mf2_snoop.sv
rtl/mf2_ram.sv
rtl/mf2_pager.sv
rtl/cpc_mem_top.sv
sim/tb_clock.sv
sim/cpc_mem_assert.sv
sim/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f src.f -o tb_sim || exit 1
out="$(./obj_dir/tb_sim)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx '=== PASS ===' && exit 0 || exit 1

// File: sim/testdata_mem.txt
# Commands, fields in hex: L level | D index addr data valid boot_addr | M bit exp
# K | F addr | O addr data | S addr data | R addr exp | C en nmi loaded | I cycles
L 1
D 02 008123 5a 1 41c123
I 1
M 7 1
D 01 004000 c9 1 400000
I 1
M 0 1
D 04 008000 11 0 0
D 00 010000 22 0 0
# Core still held, paging must not start
K
F 0066
I 4
C 0 0 0
L 0
C 0 0 1
# NMI, enter at 0066, port paging
K
C 0 1 1
F 0066
C 1 0 1
O feea 00
C 0 0 1
O fee8 00
C 1 0 1
# Hardware register shadows
O 7f00 05
O 7f00 4a
O bc00 0c
O bd00 3f
R 3f95 4a
R 3fcf 05
R 3cff 0c
R 3dbc 3f
S 2010 a7
R 2010 a7
# Hide at 0065 blocks the paging port
F 0065
O feea 00
C 0 0 1
O fee8 00
I 2
C 0 0 1
R 3f95 ff
